// ==== acc_cpu.f ====
+incdir+sim
source/acc_cpu_pkg.sv
source/acc_ctrl_if.sv
source/pc_counter.sv
source/instr_sequencer.sv
source/acc_alu.sv
source/stack_pointer.sv
source/acc_cpu.sv
sim/acc_cpu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= acc_cpu_tb
FILELIST  ?= acc_cpu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "STATUS: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/acc_cpu_model.svh ====
// ----------------------------------------------------------------------
// Random source and program builders
// ----------------------------------------------------------------------

// 32 bit xorshift, state lives in seed
function automatic logic [31:0] xorshift32();
	seed = seed ^ (seed << 13);
	seed = seed ^ (seed >> 17);
	seed = seed ^ (seed << 5);
	return seed;
endfunction

function automatic int pick(int range);
	return int'(xorshift32() % 32'(range));    // 0 .. range-1
endfunction

function automatic void emit(acc_cpu_pkg::opcode_e op, int x);
	rom[wp] = {op, acc_cpu_pkg::operand_t'(x)};
	wp++;
endfunction

function automatic void build_program(int kind);
	int cnt;
	int prt;
	wp = 0;
	for (int i = 0; i < 512; i++) begin
		rom[i] = {acc_cpu_pkg::HLT, 9'd0};       // Stray PC stops the core
		ram[i] = xorshift32() ^ acc_cpu_pkg::word_t'(i);
	end
	for (int i = 0; i < 8; i++)
		ports[i] = xorshift32();
	case (kind)
		0: for (int k = 0; k < 8; k++) begin     // Immediates, stores and reloads
			emit(acc_cpu_pkg::LDI, pick(512));
			emit(acc_cpu_pkg::SET, 64 + k);
			emit(acc_cpu_pkg::LOD, pick(64));
			emit(acc_cpu_pkg::OUT, 7 - k);
			emit(acc_cpu_pkg::LOD, 64 + k);      // Reads back the store
			emit(acc_cpu_pkg::OUT, k);
		end
		1, 2: begin                              // ALU and compares on random words
			emit(acc_cpu_pkg::LOD, pick(32));
			for (int k = 0; k < 24; k++) begin
				cnt = pick(32);
				if (k % 6 == 0) begin            // Forces EQU to 1
					emit(acc_cpu_pkg::LOD, cnt);
					emit(acc_cpu_pkg::EQU, cnt);
				end else
					emit(acc_cpu_pkg::opcode_e'(7'(int'(acc_cpu_pkg::ADD) + pick(16))), cnt);
				emit(acc_cpu_pkg::OUT, pick(8));
			end
		end
		3: begin                                 // Countdown loop
			cnt = 3 + pick(6);
			prt = pick(8);
			emit(acc_cpu_pkg::LDI, 1);
			emit(acc_cpu_pkg::SET, 41);          // Decrement step
			emit(acc_cpu_pkg::LDI, cnt);
			emit(acc_cpu_pkg::SET, 40);          // Loop counter
			emit(acc_cpu_pkg::OUT, prt);         // Word 4, loop head
			emit(acc_cpu_pkg::LOD, 40);
			emit(acc_cpu_pkg::SUB, 41);
			emit(acc_cpu_pkg::SET, 40);
			emit(acc_cpu_pkg::JIZ, 10);
			emit(acc_cpu_pkg::JMP, 4);
		end
		4: begin                                 // Full stack, then drain
			for (int k = 0; k < STACK_DEPTH; k++) begin
				emit(acc_cpu_pkg::LDI, pick(512));
				emit(acc_cpu_pkg::PSH, 0);
			end
			for (int k = 0; k < STACK_DEPTH; k++) begin
				emit(acc_cpu_pkg::POP, 0);
				emit(acc_cpu_pkg::OUT, k);
			end
		end
		default: for (int k = 0; k < 8; k++) begin  // Port echo
			emit(acc_cpu_pkg::INN, k);
			emit(acc_cpu_pkg::OUT, k);
		end
	endcase
	emit(acc_cpu_pkg::HLT, 0);
endfunction

// ----------------------------------------------------------------------
// Instruction set model
// ----------------------------------------------------------------------

// Runs rom on m_ram and ports, queues the OUT events and INN ports and
// returns the instruction count with HLT, or -1 for a program that never halts
function automatic int run_model();
	acc_cpu_pkg::word_t    a;
	acc_cpu_pkg::word_t    m;                // Word at the operand address
	acc_cpu_pkg::iaddr_t   pc;
	acc_cpu_pkg::daddr_t   sp;               // Next free stack slot
	acc_cpu_pkg::operand_t x;
	acc_cpu_pkg::opcode_e  op;
	int                    n;
	a  = '0;
	pc = '0;
	sp = '1;
	n  = 0;
	exp_port.delete();
	exp_word.delete();
	exp_in_port.delete();
	for (int i = 0; i < 512; i++)
		m_ram[i] = ram[i];
	while (n < MAX_STEPS) begin
		op = acc_cpu_pkg::opcode_e'(rom[pc][15:9]);
		x  = rom[pc][8:0];
		m  = m_ram[x];
		n++;
		pc = pc + 1'b1;
		case (op)
			acc_cpu_pkg::LOD: a = m;
			acc_cpu_pkg::SET: m_ram[x] = a;
			acc_cpu_pkg::LDI: a = {{23{x[8]}}, x};
			acc_cpu_pkg::ADD: a = a + m;
			acc_cpu_pkg::SUB: a = a - m;
			acc_cpu_pkg::MLT: a = a * m;         // Wraps to 32 bits
			acc_cpu_pkg::AND: a = a & m;
			acc_cpu_pkg::OR:  a = a | m;
			acc_cpu_pkg::XOR: a = a ^ m;
			acc_cpu_pkg::INV: a = ~a;
			acc_cpu_pkg::SHL: a = a << m[4:0];
			acc_cpu_pkg::SHR: a = a >> m[4:0];
			acc_cpu_pkg::SRS: a = $signed(a) >>> m[4:0];
			acc_cpu_pkg::NEG: a = -a;
			acc_cpu_pkg::ABS: a = a[31] ? -a : a;
			acc_cpu_pkg::NRM: a = $signed(a) >>> NORM_SHIFT;
			acc_cpu_pkg::GRE: a = {31'd0, $signed(a) > $signed(m)};
			acc_cpu_pkg::LES: a = {31'd0, $signed(a) < $signed(m)};
			acc_cpu_pkg::EQU: a = {31'd0, a == m};
			acc_cpu_pkg::PSH: begin
				m_ram[sp] = a;
				sp = sp - 1'b1;
			end
			acc_cpu_pkg::POP: begin
				sp = sp + 1'b1;
				a  = m_ram[sp];
			end
			acc_cpu_pkg::INN: begin
				a = ports[x[2:0]];
				exp_in_port.push_back(x[2:0]);
			end
			acc_cpu_pkg::OUT: begin
				exp_port.push_back(x[2:0]);
				exp_word.push_back(a);
			end
			acc_cpu_pkg::JMP: pc = x;
			acc_cpu_pkg::JIZ: if (a == '0) pc = x;
			acc_cpu_pkg::HLT: return n;
			default: ;
		endcase
	end
	return -1;
endfunction

// ==== sim/acc_cpu_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module acc_cpu_tb;

	localparam int STACK_DEPTH = 16;
	localparam int NORM_SHIFT  = 6;
	localparam int NPROG       = 6;           // Builder kinds 0 to 5
	localparam int MAX_STEPS   = 128;         // Instruction budget per program
	localparam int RST_CYCLES  = 16;
	localparam int WATCHDOG_NS = 2 * NPROG * (MAX_STEPS * 3 + RST_CYCLES + 1) * 4;

	logic                clk;
	logic                rst;
	acc_cpu_pkg::instr_t instr;
	acc_cpu_pkg::iaddr_t instr_addr;
	logic                mem_wr;
	acc_cpu_pkg::daddr_t mem_addr_w;
	acc_cpu_pkg::daddr_t mem_addr_r;
	acc_cpu_pkg::word_t  mem_data_in;
	acc_cpu_pkg::word_t  data_out;
	acc_cpu_pkg::word_t  io_in;
	acc_cpu_pkg::port_t  addr_in;
	acc_cpu_pkg::port_t  addr_out;
	logic                req_in;
	logic                out_en;
	logic                halted;

	acc_cpu_pkg::instr_t rom [512];
	acc_cpu_pkg::word_t  ram [512];
	acc_cpu_pkg::word_t  ports [8];          // Input port table
	acc_cpu_pkg::word_t  m_ram [512];        // Expected final RAM
	acc_cpu_pkg::port_t  exp_port [$];
	acc_cpu_pkg::word_t  exp_word [$];
	acc_cpu_pkg::port_t  exp_in_port [$];    // Ports read by INN, in order
	logic [31:0]         seed;
	int                  wp;                 // ROM fill pointer
	int                  cyc;                // Cycle number since reset release
	int                  n_exp;              // Model instruction count
	bit                  halt_seen;

	`include "acc_cpu_model.svh"

	acc_cpu #(.STACK_DEPTH(STACK_DEPTH), .NORM_SHIFT(NORM_SHIFT)) uut (.*);

	always #2 clk = ~clk;                    // 4 ns period

	// Synchronous ROM and RAM, data one cycle after the address
	always @(posedge clk) begin
		instr       <= rom[instr_addr];
		mem_data_in <= ram[mem_addr_r];      // Old word on a same cycle write
		if (mem_wr)
			ram[mem_addr_w] = data_out;
	end

	always @(negedge clk)
		io_in <= ports[addr_in];             // Port answer

	always @(posedge clk or posedge rst)
		if (rst)
			cyc <= 0;
		else
			cyc <= cyc + 1;

	// ----------------------------------------------------------------------
	// Compare tasks
	// ----------------------------------------------------------------------

	task automatic abort_run(string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	task automatic check_word(string name, acc_cpu_pkg::word_t got, acc_cpu_pkg::word_t exp);
		if (got !== exp)
			abort_run($sformatf("Error at %0d ns: %s = %h, expected %h", $time, name, got, exp));
	endtask

	task automatic check_port(string name, acc_cpu_pkg::port_t got, acc_cpu_pkg::port_t exp);
		if (got !== exp)
			abort_run($sformatf("Error at %0d ns: %s = %0d, expected %0d", $time, name, got, exp));
	endtask

	task automatic check_count(string name, int got, int exp);
		if (got != exp)
			abort_run($sformatf("Error at %0d ns: %s = %0d, expected %0d", $time, name, got, exp));
	endtask

	// ----------------------------------------------------------------------
	// Monitor, stimulus and watchdog
	// ----------------------------------------------------------------------

	always @(negedge clk) begin
		if (!rst) begin
			if ((out_en || req_in) && cyc % 3 != 2)  // EXECUTE is cycle 3k+2
				abort_run($sformatf("Port strobe outside EXECUTE in cycle %0d", cyc));
			if (req_in) begin
				if (exp_in_port.size() == 0)
					abort_run("INN request that the model does not expect");
				else
					check_port("addr_in", addr_in, exp_in_port.pop_front());
			end
			if (out_en) begin
				if (exp_word.size() == 0)
					abort_run("OUT event that the model does not expect");
				else begin
					check_port("addr_out", addr_out, exp_port.pop_front());
					check_word("data_out", data_out, exp_word.pop_front());
				end
			end
			if (halted && !halt_seen) begin
				check_count("halt cycle", cyc, 3 * n_exp);  // One past HLT EXECUTE
				halt_seen = 1'b1;
			end
		end
	end

	initial begin
		clk         = 1'b0;
		rst         <= 1'b1;
		instr       <= '0;
		mem_data_in <= '0;
		io_in       <= '0;
		seed        = 32'h02b6fdab;
		halt_seen   = 1'b0;
		for (int t = 0; t < NPROG; t++) begin
			@(negedge clk);
			rst <= 1'b1;
			build_program(t);
			n_exp = run_model();
			if (n_exp < 0)
				abort_run("Reference model did not reach HLT");
			repeat (RST_CYCLES) @(negedge clk);
			halt_seen = 1'b0;
			rst       <= 1'b0;
			wait (halt_seen);
			for (int a = 0; a < 512; a++)
				check_word($sformatf("ram[%0d]", a), ram[a], m_ram[a]);
			check_count("missing OUT events", exp_word.size(), 0);
			check_count("missing INN requests", exp_in_port.size(), 0);
		end
		$display("STATUS: PASS");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		abort_run("Watchdog expired before all programs halted");
	end

endmodule

`default_nettype wire

// ==== source/acc_cpu.sv ====
`timescale 1ns/10ps
`default_nettype none

module acc_cpu #(
	parameter int STACK_DEPTH = 16,
	parameter int NORM_SHIFT  = 6
) (
	input  logic                clk,
	input  logic                rst,

	input  acc_cpu_pkg::instr_t instr,        // Registered ROM data
	output acc_cpu_pkg::iaddr_t instr_addr,

	output logic                mem_wr,
	output acc_cpu_pkg::daddr_t mem_addr_w,
	output acc_cpu_pkg::daddr_t mem_addr_r,
	input  acc_cpu_pkg::word_t  mem_data_in,  // Registered RAM data
	output acc_cpu_pkg::word_t  data_out,

	input  acc_cpu_pkg::word_t  io_in,
	output acc_cpu_pkg::port_t  addr_in,
	output acc_cpu_pkg::port_t  addr_out,
	output logic                req_in,
	output logic                out_en,
	output logic                halted
);

	logic                pc_inc;
	logic                pc_load;
	acc_cpu_pkg::iaddr_t pc_target;
	acc_cpu_pkg::daddr_t op_addr;             // Operand address
	acc_cpu_pkg::port_t  port;
	acc_cpu_pkg::daddr_t sp_addr_w;
	acc_cpu_pkg::daddr_t sp_addr_r;
	acc_cpu_pkg::word_t  acc;
	logic                zero;

	acc_ctrl_if ctrl ();

	// ----------------------------------------------------------------------
	// Control path
	// ----------------------------------------------------------------------

	pc_counter u_pc (
		.clk    (clk),
		.rst    (rst),
		.inc    (pc_inc),
		.load   (pc_load),
		.target (pc_target),
		.pc     (instr_addr)           // PC drives ROM directly
	);

	instr_sequencer u_seq (
		.clk       (clk),
		.rst       (rst),
		.instr     (instr),
		.zero      (zero),
		.ctrl      (ctrl.seq),
		.pc_inc    (pc_inc),
		.pc_load   (pc_load),
		.pc_target (pc_target),
		.mem_addr  (op_addr),
		.port      (port),
		.req_in    (req_in),
		.out_en    (out_en),
		.halted    (halted)
	);

	// ----------------------------------------------------------------------
	// Datapath
	// ----------------------------------------------------------------------

	acc_alu #(.NORM_SHIFT(NORM_SHIFT)) u_alu (
		.clk      (clk),
		.rst      (rst),
		.ctrl     (ctrl.dp),
		.mem_data (mem_data_in),
		.io_data  (io_in),
		.acc      (acc),
		.zero     (zero)
	);

	stack_pointer #(.STACK_DEPTH(STACK_DEPTH)) u_sp (
		.clk    (clk),
		.rst    (rst),
		.ctrl   (ctrl.dp),
		.addr_w (sp_addr_w),
		.addr_r (sp_addr_r)
	);

	// Pop read must be addressed in DECODE, ahead of the pop strobe
	assign mem_addr_r = (ctrl.alu_op == acc_cpu_pkg::PASS_STK) ? sp_addr_r : op_addr;
	assign mem_addr_w = ctrl.push ? sp_addr_w : op_addr;
	assign mem_wr     = ctrl.mem_wr;
	assign data_out   = acc;                  // SET, PSH and OUT all send acc
	assign addr_in    = port;
	assign addr_out   = port;

endmodule

`default_nettype wire

// ==== source/stack_pointer.sv ====
`timescale 1ns/10ps
`default_nettype none

module stack_pointer #(
	parameter int STACK_DEPTH = 16             // Entries at the top of RAM
) (
	input  logic                clk,
	input  logic                rst,
	acc_ctrl_if.dp              ctrl,
	output acc_cpu_pkg::daddr_t addr_w,        // Push address
	output acc_cpu_pkg::daddr_t addr_r         // Pop address
);

	acc_cpu_pkg::daddr_t sp;                   // Next free slot
	acc_cpu_pkg::daddr_t used;
	logic                full;
	logic                empty;

	assign used   = ~sp;                      // 511 minus sp
	assign full   = (used == acc_cpu_pkg::daddr_t'(STACK_DEPTH));
	assign empty  = (used == '0);
	assign addr_w = sp;
	assign addr_r = sp + 1'b1;                // Last pushed word

	// ----------------------------------------------------------------------
	// Pointer update
	// ----------------------------------------------------------------------

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			sp <= '1;                         // Stack starts at word 511
		else if (ctrl.push && !full)
			sp <= sp - 1'b1;                  // Grows down
		else if (ctrl.pop && !empty)
			sp <= sp + 1'b1;
	end

	// Program must respect stack depth
	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		ctrl.push |-> !full);

	a_no_underflow: assert property (@(posedge clk) disable iff (rst)
		ctrl.pop |-> !empty);

	// A push always writes the RAM
	a_push_writes: assert property (@(posedge clk) disable iff (rst)
		ctrl.push |-> ctrl.mem_wr && !ctrl.pop);

endmodule

`default_nettype wire

// ==== source/acc_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module acc_alu #(
	parameter int NORM_SHIFT = 6               // NRM divides by 2**NORM_SHIFT
) (
	input  logic               clk,
	input  logic               rst,
	acc_ctrl_if.dp             ctrl,
	input  acc_cpu_pkg::word_t mem_data,       // RAM word for this instruction
	input  acc_cpu_pkg::word_t io_data,        // Input port value
	output acc_cpu_pkg::word_t acc,
	output logic               zero
);

	acc_cpu_pkg::word_t acc_nxt;
	acc_cpu_pkg::word_t imm_ext;
	logic [4:0]         shamt;

	// Sign extended 9 bit immediate
	assign imm_ext = {{(acc_cpu_pkg::DATA_W - acc_cpu_pkg::OPER_W){ctrl.imm[acc_cpu_pkg::OPER_W-1]}},
		ctrl.imm};
	assign shamt   = mem_data[4:0];            // Shifts take count from RAM

	// ----------------------------------------------------------------------
	// Next accumulator value
	// ----------------------------------------------------------------------

	always_comb begin
		case (ctrl.alu_op)
			acc_cpu_pkg::PASS_MEM,
			acc_cpu_pkg::PASS_STK: acc_nxt = mem_data;
			acc_cpu_pkg::PASS_IMM: acc_nxt = imm_ext;
			acc_cpu_pkg::PASS_IO:  acc_nxt = io_data;
			acc_cpu_pkg::ALU_ADD:  acc_nxt = acc + mem_data;
			acc_cpu_pkg::ALU_SUB:  acc_nxt = acc - mem_data;
			acc_cpu_pkg::ALU_MLT:  acc_nxt = acc * mem_data;  // Low 32 bits kept
			acc_cpu_pkg::ALU_AND:  acc_nxt = acc & mem_data;
			acc_cpu_pkg::ALU_OR:   acc_nxt = acc | mem_data;
			acc_cpu_pkg::ALU_XOR:  acc_nxt = acc ^ mem_data;
			acc_cpu_pkg::ALU_INV:  acc_nxt = ~acc;
			acc_cpu_pkg::ALU_SHL:  acc_nxt = acc << shamt;
			acc_cpu_pkg::ALU_SHR:  acc_nxt = acc >> shamt;
			acc_cpu_pkg::ALU_SRS:
				acc_nxt = acc_cpu_pkg::word_t'($signed(acc) >>> shamt);
			acc_cpu_pkg::ALU_NEG:  acc_nxt = -acc;
			acc_cpu_pkg::ALU_ABS:  acc_nxt = acc[acc_cpu_pkg::DATA_W-1] ? -acc : acc;
			acc_cpu_pkg::ALU_NRM:
				acc_nxt = acc_cpu_pkg::word_t'($signed(acc) >>> NORM_SHIFT);  // Floors
			acc_cpu_pkg::ALU_GRE:
				acc_nxt = acc_cpu_pkg::word_t'($signed(acc) > $signed(mem_data));
			acc_cpu_pkg::ALU_LES:
				acc_nxt = acc_cpu_pkg::word_t'($signed(acc) < $signed(mem_data));
			acc_cpu_pkg::ALU_EQU:
				acc_nxt = acc_cpu_pkg::word_t'(acc == mem_data);
			default:               acc_nxt = acc;               // HOLD
		endcase
	end

	// ----------------------------------------------------------------------
	// Accumulator register
	// ----------------------------------------------------------------------

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			acc <= '0;
		else if (ctrl.acc_load)
			acc <= acc_nxt;
	end

	assign zero = (acc == '0);                 // Drives JIZ

	// RAM writes always see a settled accumulator
	a_wr_no_load: assert property (@(posedge clk) disable iff (rst)
		ctrl.mem_wr |-> !ctrl.acc_load ##1 $stable(acc));

endmodule

`default_nettype wire

// ==== source/instr_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module instr_sequencer (
	input  logic                clk,
	input  logic                rst,
	input  acc_cpu_pkg::instr_t instr,      // Registered ROM word
	input  logic                zero,       // Accumulator is zero
	acc_ctrl_if.seq             ctrl,
	output logic                pc_inc,
	output logic                pc_load,
	output acc_cpu_pkg::iaddr_t pc_target,
	output acc_cpu_pkg::daddr_t mem_addr,   // Direct operand address
	output acc_cpu_pkg::port_t  port,       // I/O port number
	output logic                req_in,
	output logic                out_en,
	output logic                halted
);

	typedef enum logic [1:0] {FETCH, DECODE, EXECUTE, HALT} state_e;

	state_e                state;
	state_e                state_nxt;
	acc_cpu_pkg::opcode_e  opc;
	acc_cpu_pkg::operand_t operand;
	acc_cpu_pkg::alu_op_e  dec_op;
	logic                  dec_wr, dec_push, dec_pop;
	logic                  dec_inn, dec_out, dec_jump, dec_halt;
	logic                  exec;

	// Fields stay valid through DECODE and EXECUTE since PC is held
	assign opc     = acc_cpu_pkg::opcode_e'(instr[acc_cpu_pkg::INSTR_W-1 -: acc_cpu_pkg::OPC_W]);
	assign operand = instr[acc_cpu_pkg::OPER_W-1:0];

	// ----------------------------------------------------------------------
	// Opcode decode
	// ----------------------------------------------------------------------

	always_comb begin
		dec_op   = acc_cpu_pkg::HOLD;
		dec_wr   = 1'b0;
		dec_push = 1'b0;
		dec_pop  = 1'b0;
		dec_inn  = 1'b0;
		dec_out  = 1'b0;
		dec_jump = 1'b0;
		dec_halt = 1'b0;
		case (opc)
			acc_cpu_pkg::LOD: dec_op = acc_cpu_pkg::PASS_MEM;
			acc_cpu_pkg::LDI: dec_op = acc_cpu_pkg::PASS_IMM;
			acc_cpu_pkg::SET: dec_wr = 1'b1;
			acc_cpu_pkg::ADD: dec_op = acc_cpu_pkg::ALU_ADD;
			acc_cpu_pkg::SUB: dec_op = acc_cpu_pkg::ALU_SUB;
			acc_cpu_pkg::MLT: dec_op = acc_cpu_pkg::ALU_MLT;
			acc_cpu_pkg::AND: dec_op = acc_cpu_pkg::ALU_AND;
			acc_cpu_pkg::OR:  dec_op = acc_cpu_pkg::ALU_OR;
			acc_cpu_pkg::XOR: dec_op = acc_cpu_pkg::ALU_XOR;
			acc_cpu_pkg::INV: dec_op = acc_cpu_pkg::ALU_INV;
			acc_cpu_pkg::SHL: dec_op = acc_cpu_pkg::ALU_SHL;
			acc_cpu_pkg::SHR: dec_op = acc_cpu_pkg::ALU_SHR;
			acc_cpu_pkg::SRS: dec_op = acc_cpu_pkg::ALU_SRS;
			acc_cpu_pkg::NEG: dec_op = acc_cpu_pkg::ALU_NEG;
			acc_cpu_pkg::ABS: dec_op = acc_cpu_pkg::ALU_ABS;
			acc_cpu_pkg::NRM: dec_op = acc_cpu_pkg::ALU_NRM;
			acc_cpu_pkg::GRE: dec_op = acc_cpu_pkg::ALU_GRE;
			acc_cpu_pkg::LES: dec_op = acc_cpu_pkg::ALU_LES;
			acc_cpu_pkg::EQU: dec_op = acc_cpu_pkg::ALU_EQU;
			acc_cpu_pkg::PSH: begin
				dec_push = 1'b1;
				dec_wr   = 1'b1;                     // Accumulator goes to stack top
			end
			acc_cpu_pkg::POP: begin
				dec_pop = 1'b1;
				dec_op  = acc_cpu_pkg::PASS_STK;    // Also steers the read address
			end
			acc_cpu_pkg::INN: begin
				dec_inn = 1'b1;
				dec_op  = acc_cpu_pkg::PASS_IO;
			end
			acc_cpu_pkg::OUT: dec_out  = 1'b1;
			acc_cpu_pkg::JMP: dec_jump = 1'b1;
			acc_cpu_pkg::JIZ: dec_jump = zero;      // Flag of acc before JIZ
			acc_cpu_pkg::HLT: dec_halt = 1'b1;
			default: ;                              // NOP and unused codes
		endcase
	end

	// ----------------------------------------------------------------------
	// State machine
	// ----------------------------------------------------------------------

	always_comb begin
		case (state)
			FETCH:   state_nxt = DECODE;
			DECODE:  state_nxt = EXECUTE;
			EXECUTE: state_nxt = dec_halt ? HALT : FETCH;
			default: state_nxt = HALT;              // Only reset leaves HALT
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			state <= FETCH;
		else
			state <= state_nxt;
	end

	// Strobes only fire in EXECUTE
	assign exec          = (state == EXECUTE);
	assign ctrl.alu_op   = dec_op;
	assign ctrl.imm      = operand;
	assign ctrl.acc_load = exec && (dec_op != acc_cpu_pkg::HOLD);
	assign ctrl.mem_wr   = exec && dec_wr;
	assign ctrl.push     = exec && dec_push;
	assign ctrl.pop      = exec && dec_pop;
	assign req_in        = exec && dec_inn;
	assign out_en        = exec && dec_out;
	assign pc_load       = exec && dec_jump;
	assign pc_inc        = exec && !dec_jump && !dec_halt;  // PC freezes on HLT
	assign pc_target     = operand;
	assign mem_addr      = operand;
	assign port          = operand[acc_cpu_pkg::PORT_W-1:0];
	assign halted        = (state == HALT);

	// Every strobe is preceded by a DECODE cycle
	a_strobe_exec: assert property (@(posedge clk) disable iff (rst)
		(ctrl.acc_load || ctrl.mem_wr || ctrl.push || ctrl.pop || req_in || out_en)
		|-> exec && $past(state) == DECODE);

	// Halt is sticky until reset
	a_halt_sticky: assert property (@(posedge clk) disable iff (rst)
		halted |=> halted && state == HALT);

endmodule

`default_nettype wire

// ==== source/pc_counter.sv ====
`timescale 1ns/10ps
`default_nettype none

module pc_counter (
	input  logic                clk,
	input  logic                rst,
	input  logic                inc,     // Step to next instruction
	input  logic                load,    // Taken jump
	input  acc_cpu_pkg::iaddr_t target,  // Jump destination
	output acc_cpu_pkg::iaddr_t pc
);

	// ----------------------------------------------------------------------
	// Program counter register
	// ----------------------------------------------------------------------

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc <= '0;                    // Program starts at word 0
		end else if (load) begin
			pc <= target;
		end else if (inc) begin
			pc <= pc + 1'b1;             // Wraps at end of ROM
		end
	end

	// ----------------------------------------------------------------------
	// Checks
	// ----------------------------------------------------------------------

	// Sequencer picks either step or jump, never both
	a_inc_load_excl: assert property (@(posedge clk) disable iff (rst)
		!(inc && load));

endmodule

`default_nettype wire

// ==== source/acc_ctrl_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// Decoded control from the sequencer to the datapath blocks
interface acc_ctrl_if;

	acc_cpu_pkg::alu_op_e  alu_op;    // Valid from DECODE on
	acc_cpu_pkg::operand_t imm;       // Raw operand field
	logic                  acc_load;  // Accumulator write enable
	logic                  push;      // Stack push strobe
	logic                  pop;       // Stack pop strobe
	logic                  mem_wr;    // Data RAM write strobe

	// Sequencer side
	modport seq (
		output alu_op,
		output imm,
		output acc_load,
		output push,
		output pop,
		output mem_wr
	);

	// ALU and stack pointer side
	modport dp (
		input alu_op,
		input imm,
		input acc_load,
		input push,
		input pop,
		input mem_wr
	);

endinterface

`default_nettype wire

// ==== source/acc_cpu_pkg.sv ====
`default_nettype none

package acc_cpu_pkg;

	// ----------------------------------------------------------------------
	// Widths
	// ----------------------------------------------------------------------

	localparam int DATA_W  = 32;                // Accumulator and RAM word
	localparam int OPER_W  = 9;                 // Instruction operand
	localparam int OPC_W   = 7;                 // Opcode field
	localparam int INSTR_W = OPC_W + OPER_W;    // Full instruction word
	localparam int PORT_W  = 3;                 // Eight ports each way

	typedef logic [DATA_W-1:0]  word_t;
	typedef logic [OPER_W-1:0]  operand_t;
	typedef logic [OPER_W-1:0]  iaddr_t;        // Instruction ROM address
	typedef logic [OPER_W-1:0]  daddr_t;        // Data RAM address
	typedef logic [PORT_W-1:0]  port_t;
	typedef logic [INSTR_W-1:0] instr_t;        // Opcode sits on top

	// ----------------------------------------------------------------------
	// Encodings
	// ----------------------------------------------------------------------

	typedef enum logic [OPC_W-1:0] {
		NOP = 7'd0, LOD, SET, LDI,
		ADD, SUB, MLT, AND, OR, XOR, INV,
		SHL, SHR, SRS, NEG, ABS, NRM,
		GRE, LES, EQU,
		PSH, POP,
		INN, OUT,
		JMP, JIZ,
		HLT
	} opcode_e;

	// Accumulator source select
	typedef enum logic [4:0] {
		HOLD = 5'd0,
		PASS_MEM, PASS_STK, PASS_IMM, PASS_IO,  // Plain loads
		ALU_ADD, ALU_SUB, ALU_MLT,
		ALU_AND, ALU_OR, ALU_XOR, ALU_INV,
		ALU_SHL, ALU_SHR, ALU_SRS,
		ALU_NEG, ALU_ABS, ALU_NRM,
		ALU_GRE, ALU_LES, ALU_EQU               // Leave 1 or 0
	} alu_op_e;

endpackage

`default_nettype wire
